// File: hdl/dmg_clk_pkg.sv
// Shared constants for the console clock, reset and timer block
package dmg_clk_pkg;

	// Phase sequencer
	localparam int PHASE_W = 2;

	// CPU_PHI high from this phase to the end of the cycle
	localparam logic [PHASE_W-1:0] PHASE_DATA_START = 2'd2;
	localparam logic [PHASE_W-1:0] PHASE_TICK = 2'd3;	// Last phase of a machine cycle

	// Divider
	localparam int DIV_W = 16;

	// Stand-in for the 16 Hz tap, kept low so simulation stays short
	localparam int STABLE_BIT = 3;

	// Divider taps picked by TAC clock select
	localparam int TAC_SEL_BIT0 = 7;
	localparam int TAC_SEL_BIT1 = 1;
	localparam int TAC_SEL_BIT2 = 3;
	localparam int TAC_SEL_BIT3 = 5;

	// APB register map
	localparam int ADDR_W = 3;
	localparam int DATA_W = 8;

	localparam logic [ADDR_W-1:0] ADDR_DIV = 3'd0;
	localparam logic [ADDR_W-1:0] ADDR_TIMA = 3'd1;
	localparam logic [ADDR_W-1:0] ADDR_TMA = 3'd2;
	localparam logic [ADDR_W-1:0] ADDR_TAC = 3'd3;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 3'd4;	// Highest valid address

endpackage

// File: hdl/clk_phase_gen.sv
`timescale 1ns/10ps
// Four-phase sequencer making the CPU bus strobes and the machine-cycle tick
module clk_phase_gen (
	input  logic clk,
	input  logic reset,
	input  logic clk_ena,
	input  logic osc_ena,
	output logic adr_strobe,
	output logic data_strobe,
	output logic inc_strobe,
	output logic latch_strobe,
	output logic main_tick
);

	logic [dmg_clk_pkg::PHASE_W-1:0] phase;
	logic adr_d;
	logic data_d;
	logic inc_d;
	logic latch_d;
	logic tick_d;

	// Phase counter, frozen while clk_ena is low
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= '0;
		end else if (clk_ena) begin
			phase <= phase + 1'b1;
		end
	end

	// Strobe decode of the current phase
	always_comb begin
		data_d = (phase >= dmg_clk_pkg::PHASE_DATA_START);	// CPU_PHI
		inc_d = (phase == dmg_clk_pkg::PHASE_TICK);	// CPU_T4
		latch_d = (phase == 2'd1);	// BUKE
		adr_d = osc_ena & (phase != dmg_clk_pkg::PHASE_TICK);

		// Only when the counter actually leaves the last phase
		// so a stopped sequencer never stretches the tick
		tick_d = clk_ena & osc_ena & (phase == dmg_clk_pkg::PHASE_TICK);
	end

	// Registered strobes, one clock behind the phase
	always_ff @(posedge clk) begin
		if (reset) begin
			adr_strobe <= 1'b0;
			data_strobe <= 1'b0;
			inc_strobe <= 1'b0;
			latch_strobe <= 1'b0;
			main_tick <= 1'b0;
		end else begin
			adr_strobe <= adr_d;
			data_strobe <= data_d;
			inc_strobe <= inc_d;
			latch_strobe <= latch_d;
			main_tick <= tick_d;	// BOGA
		end
	end

endmodule

// File: hdl/reset_seq.sv
`timescale 1ns/10ps
// Oscillator-stable latch and machine-cycle aligned CPU reset release
module reset_seq (
	input  logic clk,
	input  logic reset,
	input  logic clk_ena,
	input  logic osc_ena,
	input  logic main_tick,
	input  logic stable_src,
	output logic osc_stable,
	output logic sync_reset
);

	logic stable_q;	// TUBO
	logic sync_reset_q;	// AFER

	// Set once the divider tap is seen high on a running tick
	always_ff @(posedge clk) begin
		if (reset) begin
			stable_q <= 1'b0;
		end else if (!osc_ena) begin
			stable_q <= 1'b0;	// Oscillator off drops it at once
		end else if (main_tick && clk_ena && stable_src) begin
			stable_q <= 1'b1;
		end
	end

	// CPU reset held until a tick arrives with the oscillator stable
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_reset_q <= 1'b1;
		end else if (!stable_q) begin
			sync_reset_q <= 1'b1;	// Re-asserts the CPU reset after a drop
		end else if (main_tick) begin
			sync_reset_q <= 1'b0;
		end
	end

	assign osc_stable = stable_q;
	assign sync_reset = sync_reset_q;

endmodule

// File: hdl/div_timer.sv
`timescale 1ns/10ps
// Divider and timer unit with modulo reload and overflow interrupt
module div_timer (
	input  logic clk,
	input  logic reset,
	input  logic main_tick,
	input  logic sync_reset,
	input  logic div_clear,
	input  logic tima_wr,
	input  logic tma_wr,
	input  logic tac_wr,
	input  logic irq_clear,
	input  logic [dmg_clk_pkg::DATA_W-1:0] wdata,
	output logic [dmg_clk_pkg::DATA_W-1:0] div_hi,
	output logic [dmg_clk_pkg::DATA_W-1:0] tima,
	output logic [dmg_clk_pkg::DATA_W-1:0] tma,
	output logic [dmg_clk_pkg::DATA_W-1:0] tac,
	output logic stable_src,
	output logic timer_irq
);

	logic [dmg_clk_pkg::DIV_W-1:0] div_q;
	logic [dmg_clk_pkg::DATA_W-1:0] tima_q;
	logic [dmg_clk_pkg::DATA_W-1:0] tma_q;
	logic [2:0] tac_q;	// Enable and clock select
	logic irq_q;
	logic sel_bit;
	logic sel_bit_q;
	logic tima_inc;
	logic tima_ovf;

	// Free-running divider, one count per machine cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			div_q <= '0;
		end else if (div_clear) begin
			div_q <= '0;
		end else if (main_tick) begin
			div_q <= div_q + 1'b1;
		end
	end

	// Divider tap picked by TAC
	always_comb begin
		case (tac_q[1:0])
			2'd0: sel_bit = div_q[dmg_clk_pkg::TAC_SEL_BIT0];
			2'd1: sel_bit = div_q[dmg_clk_pkg::TAC_SEL_BIT1];
			2'd2: sel_bit = div_q[dmg_clk_pkg::TAC_SEL_BIT2];
			default: sel_bit = div_q[dmg_clk_pkg::TAC_SEL_BIT3];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sel_bit_q <= 1'b0;
		end else begin
			sel_bit_q <= sel_bit;
		end
	end

	// A falling tap counts, so a DIV clear can bump TIMA as on the real chip
	assign tima_inc = sel_bit_q & ~sel_bit & tac_q[2] & ~sync_reset;
	assign tima_ovf = tima_inc & (tima_q == '1);

	always_ff @(posedge clk) begin
		if (reset) begin
			tima_q <= '0;
		end else if (tima_wr) begin
			tima_q <= wdata;	// Write beats the count
		end else if (tima_ovf) begin
			tima_q <= tma_q;	// Modulo reload
		end else if (tima_inc) begin
			tima_q <= tima_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tma_q <= '0;
			tac_q <= '0;
		end else begin
			if (tma_wr)
				tma_q <= wdata;
			if (tac_wr)
				tac_q <= wdata[2:0];
		end
	end

	// Overflow flag, no set when a TIMA write took the cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			irq_q <= 1'b0;
		end else if (irq_clear) begin
			irq_q <= 1'b0;
		end else if (tima_ovf && !tima_wr) begin
			irq_q <= 1'b1;
		end
	end

	assign div_hi = div_q[dmg_clk_pkg::DIV_W-1 -: dmg_clk_pkg::DATA_W];
	assign tima = tima_q;
	assign tma = tma_q;
	assign tac = {{(dmg_clk_pkg::DATA_W-3){1'b0}}, tac_q};
	assign stable_src = div_q[dmg_clk_pkg::STABLE_BIT];
	assign timer_irq = irq_q;

endmodule

// File: hdl/timer_apb_regs.sv
`timescale 1ns/10ps
// APB slave for the divider, timer and status registers
module timer_apb_regs (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [dmg_clk_pkg::ADDR_W-1:0] paddr,
	input  logic [dmg_clk_pkg::DATA_W-1:0] pwdata,
	input  logic [dmg_clk_pkg::DATA_W-1:0] div_hi,
	input  logic [dmg_clk_pkg::DATA_W-1:0] tima,
	input  logic [dmg_clk_pkg::DATA_W-1:0] tma,
	input  logic [dmg_clk_pkg::DATA_W-1:0] tac,
	input  logic timer_irq,
	input  logic osc_stable,
	input  logic sync_reset,
	output logic [dmg_clk_pkg::DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic div_clear,
	output logic tima_wr,
	output logic tma_wr,
	output logic tac_wr,
	output logic irq_clear,
	output logic [dmg_clk_pkg::DATA_W-1:0] wdata
);

	logic [dmg_clk_pkg::ADDR_W-1:0] addr_q;
	logic addr_err_q;
	logic setup;
	logic access;
	logic wr;
	logic [dmg_clk_pkg::DATA_W-1:0] status;
	logic [dmg_clk_pkg::DATA_W-1:0] rd_mux;

	assign setup = psel & ~penable;
	assign access = psel & penable;

	// Address decoded during the setup cycle, used in the access cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			addr_q <= '0;
			addr_err_q <= 1'b0;
		end else if (setup) begin
			addr_q <= paddr;
			addr_err_q <= (paddr > dmg_clk_pkg::ADDR_STATUS);
		end
	end

	assign wr = access & pwrite & ~addr_err_q;	// Bad address writes nothing

	// One-cycle strobes, registers update at the end of the access cycle
	assign div_clear = wr & (addr_q == dmg_clk_pkg::ADDR_DIV);	// Any value clears
	assign tima_wr = wr & (addr_q == dmg_clk_pkg::ADDR_TIMA);
	assign tma_wr = wr & (addr_q == dmg_clk_pkg::ADDR_TMA);
	assign tac_wr = wr & (addr_q == dmg_clk_pkg::ADDR_TAC);
	assign irq_clear = wr & (addr_q == dmg_clk_pkg::ADDR_STATUS) & pwdata[0];
	assign wdata = pwdata;

	assign status = {{(dmg_clk_pkg::DATA_W-3){1'b0}}, sync_reset, osc_stable, timer_irq};

	always_comb begin
		case (addr_q)
			dmg_clk_pkg::ADDR_DIV: rd_mux = div_hi;
			dmg_clk_pkg::ADDR_TIMA: rd_mux = tima;
			dmg_clk_pkg::ADDR_TMA: rd_mux = tma;
			dmg_clk_pkg::ADDR_TAC: rd_mux = tac;
			dmg_clk_pkg::ADDR_STATUS: rd_mux = status;
			default: rd_mux = '0;	// Unmapped reads as zero
		endcase
	end

	assign prdata = (access & ~pwrite) ? rd_mux : '0;
	assign pready = 1'b1;	// No wait states
	assign pslverr = access & addr_err_q;

endmodule

// File: hdl/dmg_clk_top.sv
`timescale 1ns/10ps
// Clock, reset and timer block top joining sequencer, reset logic, timer and APB slave
module dmg_clk_top (
	input  logic clk,
	input  logic reset,
	input  logic clk_ena,
	input  logic osc_ena,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [dmg_clk_pkg::ADDR_W-1:0] paddr,
	input  logic [dmg_clk_pkg::DATA_W-1:0] pwdata,
	output logic [dmg_clk_pkg::DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic adr_strobe,
	output logic data_strobe,
	output logic inc_strobe,
	output logic latch_strobe,
	output logic main_tick,
	output logic osc_stable,
	output logic sync_reset,
	output logic timer_irq
);

	logic stable_src;
	logic div_clear;
	logic tima_wr;
	logic tma_wr;
	logic tac_wr;
	logic irq_clear;
	logic [dmg_clk_pkg::DATA_W-1:0] wdata;
	logic [dmg_clk_pkg::DATA_W-1:0] div_hi;
	logic [dmg_clk_pkg::DATA_W-1:0] tima;
	logic [dmg_clk_pkg::DATA_W-1:0] tma;
	logic [dmg_clk_pkg::DATA_W-1:0] tac;

	clk_phase_gen u_clk_phase_gen (
		.clk(clk), .reset(reset), .clk_ena(clk_ena), .osc_ena(osc_ena),
		.adr_strobe(adr_strobe), .data_strobe(data_strobe), .inc_strobe(inc_strobe),
		.latch_strobe(latch_strobe), .main_tick(main_tick)
	);

	reset_seq u_reset_seq (
		.clk(clk), .reset(reset), .clk_ena(clk_ena), .osc_ena(osc_ena),
		.main_tick(main_tick), .stable_src(stable_src),
		.osc_stable(osc_stable), .sync_reset(sync_reset)
	);

	div_timer u_div_timer (
		.clk(clk), .reset(reset), .main_tick(main_tick), .sync_reset(sync_reset),
		.div_clear(div_clear), .tima_wr(tima_wr), .tma_wr(tma_wr), .tac_wr(tac_wr),
		.irq_clear(irq_clear), .wdata(wdata), .div_hi(div_hi), .tima(tima), .tma(tma),
		.tac(tac), .stable_src(stable_src), .timer_irq(timer_irq)
	);

	timer_apb_regs u_timer_apb_regs (
		.clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .div_hi(div_hi), .tima(tima), .tma(tma),
		.tac(tac), .timer_irq(timer_irq), .osc_stable(osc_stable),
		.sync_reset(sync_reset), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.div_clear(div_clear), .tima_wr(tima_wr), .tma_wr(tma_wr), .tac_wr(tac_wr),
		.irq_clear(irq_clear), .wdata(wdata)
	);

endmodule

// File: sim/dmg_clk_assertions.sv
`timescale 1ns/10ps
// Bound checks on strobe exclusivity, tick width and reset level
module dmg_clk_assertions (
	input  logic clk,
	input  logic reset,
	input  logic latch_strobe,
	input  logic inc_strobe,
	input  logic main_tick,
	input  logic sync_reset
);

	int fail_count = 0;

	// Latch and increment sit in different phases
	strobe_excl: assert property (@(posedge clk) disable iff (reset)
		!(latch_strobe && inc_strobe))
		else begin
			fail_count++;
			$error("latch_strobe and inc_strobe high together");
		end

	tick_single: assert property (@(posedge clk) disable iff (reset)
		main_tick |=> !main_tick)
		else begin
			fail_count++;
			$error("main_tick high in two cycles in a row");
		end

	// CPU held in reset right after a block reset
	reset_hold: assert property (@(posedge clk)
		reset |=> sync_reset)
		else begin
			fail_count++;
			$error("sync_reset low in the cycle after reset");
		end

endmodule

bind clk_phase_gen dmg_clk_assertions u_phase_checks (
	.clk(clk), .reset(reset), .latch_strobe(latch_strobe), .inc_strobe(inc_strobe),
	.main_tick(main_tick), .sync_reset(1'b1)
);

bind reset_seq dmg_clk_assertions u_reset_checks (
	.clk(clk), .reset(reset), .latch_strobe(1'b0), .inc_strobe(1'b0),
	.main_tick(main_tick), .sync_reset(sync_reset)
);

// File: sim/tb_dmg_clk.sv
`timescale 1ns/10ps
// Testbench for the clock, reset and timer block with a cycle model and APB traffic
module tb_dmg_clk;

	logic clk;
	logic reset;
	logic clk_ena;
	logic osc_ena;
	logic psel;
	logic penable;
	logic pwrite;
	logic [dmg_clk_pkg::ADDR_W-1:0] paddr;
	logic [dmg_clk_pkg::DATA_W-1:0] pwdata;
	logic [dmg_clk_pkg::DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	logic adr_strobe;
	logic data_strobe;
	logic inc_strobe;
	logic latch_strobe;
	logic main_tick;
	logic osc_stable;
	logic sync_reset;
	logic timer_irq;

	// Cycle model state
	logic [1:0] m_phase;
	logic m_adr;
	logic m_data;
	logic m_inc;
	logic m_latch;
	logic m_tick;
	logic m_stable;
	logic m_sync;
	logic [15:0] m_div;
	logic m_selq;
	logic [7:0] m_tima;
	logic [7:0] m_tma;
	logic [2:0] m_tac;
	logic m_irq;

	logic [15:0] lfsr;
	string test_name;
	int assert_fails;

	dmg_clk_top u_dmg_clk_top (
		.clk(clk), .reset(reset), .clk_ena(clk_ena), .osc_ena(osc_ena),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.adr_strobe(adr_strobe), .data_strobe(data_strobe), .inc_strobe(inc_strobe),
		.latch_strobe(latch_strobe), .main_tick(main_tick),
		.osc_stable(osc_stable), .sync_reset(sync_reset), .timer_irq(timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic rand_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [7:0] rand_bits(int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[6:0], rand_bit()};
		return r;
	endfunction

	task automatic fail_now();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_bit(string what, logic exp, logic act);
		if (exp !== act) begin
			$display("** Error [%s] %s: expected %0b, actual %0b", test_name, what, exp, act);
			fail_now();
		end
	endtask

	task automatic check_byte(string what, logic [dmg_clk_pkg::DATA_W-1:0] exp,
			logic [dmg_clk_pkg::DATA_W-1:0] act);
		if (exp !== act) begin
			$display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
			fail_now();
		end
	endtask

	task automatic check_err(string what, logic exp, logic act);
		if (exp !== act) begin
			$display("** Error [%s] %s pslverr: expected %0b, actual %0b",
				test_name, what, exp, act);
			fail_now();
		end
	endtask

	function automatic int tap_index(logic [1:0] code);
		case (code)
			2'd0: return dmg_clk_pkg::TAC_SEL_BIT0;
			2'd1: return dmg_clk_pkg::TAC_SEL_BIT1;
			2'd2: return dmg_clk_pkg::TAC_SEL_BIT2;
			default: return dmg_clk_pkg::TAC_SEL_BIT3;
		endcase
	endfunction

	function automatic logic [7:0] model_read(logic [2:0] addr);
		case (addr)
			dmg_clk_pkg::ADDR_DIV: return m_div[15:8];
			dmg_clk_pkg::ADDR_TIMA: return m_tima;
			dmg_clk_pkg::ADDR_TMA: return m_tma;
			dmg_clk_pkg::ADDR_TAC: return {5'b0, m_tac};
			dmg_clk_pkg::ADDR_STATUS: return {5'b0, m_sync, m_stable, m_irq};
			default: return 8'h00;
		endcase
	endfunction

	// Advance the model by one clock using the inputs held over the edge
	task automatic model_step();
		logic wr;
		logic sel;
		logic inc;
		logic ovf;
		logic tick;
		logic [1:0] n_phase;
		logic n_stable;
		logic n_sync;
		tick = m_tick;	// Tick before this edge
		wr = psel & penable & pwrite & (paddr <= dmg_clk_pkg::ADDR_STATUS);
		sel = m_div[tap_index(m_tac[1:0])];
		inc = m_selq & ~sel & m_tac[2] & ~m_sync;
		ovf = inc & (m_tima == 8'hFF);
		n_phase = clk_ena ? m_phase + 2'd1 : m_phase;
		n_stable = !osc_ena ? 1'b0 :
			((tick && clk_ena && m_div[dmg_clk_pkg::STABLE_BIT]) ? 1'b1 : m_stable);
		n_sync = !m_stable ? 1'b1 : (tick ? 1'b0 : m_sync);
		m_tick = clk_ena & osc_ena & (m_phase == 2'd3);
		m_data = (m_phase >= 2'd2);
		m_inc = (m_phase == 2'd3);
		m_latch = (m_phase == 2'd1);
		m_adr = osc_ena & (m_phase != 2'd3);
		m_selq = sel;
		if (wr && paddr == dmg_clk_pkg::ADDR_STATUS && pwdata[0])
			m_irq = 1'b0;
		else if (ovf && !(wr && paddr == dmg_clk_pkg::ADDR_TIMA))
			m_irq = 1'b1;
		if (wr && paddr == dmg_clk_pkg::ADDR_TIMA)
			m_tima = pwdata;	// Write beats count
		else if (ovf)
			m_tima = m_tma;
		else if (inc)
			m_tima = m_tima + 8'd1;
		if (wr && paddr == dmg_clk_pkg::ADDR_TMA)
			m_tma = pwdata;
		if (wr && paddr == dmg_clk_pkg::ADDR_TAC)
			m_tac = pwdata[2:0];
		if (wr && paddr == dmg_clk_pkg::ADDR_DIV)
			m_div = '0;
		else if (tick)
			m_div = m_div + 16'd1;
		m_phase = n_phase;
		m_stable = n_stable;
		m_sync = n_sync;
	endtask

	task automatic model_reset();
		m_phase = '0;
		{m_adr, m_data, m_inc, m_latch, m_tick} = '0;
		m_stable = 1'b0;
		m_sync = 1'b1;
		m_div = '0;
		m_selq = 1'b0;
		m_tima = '0;
		m_tma = '0;
		m_tac = '0;
		m_irq = 1'b0;
	endtask

	// One clock, then compare every strobe and status output
	task automatic cycle();
		@(posedge clk);
		#1;
		if (reset)
			model_reset();
		else
			model_step();
		check_bit("adr_strobe", m_adr, adr_strobe);
		check_bit("data_strobe", m_data, data_strobe);
		check_bit("inc_strobe", m_inc, inc_strobe);
		check_bit("latch_strobe", m_latch, latch_strobe);
		check_bit("main_tick", m_tick, main_tick);
		check_bit("osc_stable", m_stable, osc_stable);
		check_bit("sync_reset", m_sync, sync_reset);
		check_bit("timer_irq", m_irq, timer_irq);
	endtask

	task automatic apb_read(logic [2:0] addr);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		cycle();
		penable = 1'b1;
		#2;
		check_byte($sformatf("read addr %0d", addr), model_read(addr), prdata);
		check_err($sformatf("read addr %0d", addr),
			addr > dmg_clk_pkg::ADDR_STATUS, pslverr);
		check_bit("pready", 1'b1, pready);
		cycle();
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(logic [2:0] addr, logic [7:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		cycle();
		penable = 1'b1;
		#2;
		check_err($sformatf("write addr %0d", addr),
			addr > dmg_clk_pkg::ADDR_STATUS, pslverr);
		cycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic wait_sync(logic level, string what);
		int n;
		n = 0;
		while (sync_reset !== level) begin
			cycle();
			n++;
			if (n > 500) begin
				$display("Timeout waiting for %s", what);
				fail_now();
			end
		end
	endtask

	initial begin
		lfsr = 16'd98;
		model_reset();
		reset = 1'b1;
		clk_ena = 1'b0;
		osc_ena = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		test_name = "reset";
		repeat (3) cycle();
		reset = 1'b0;

		test_name = "strobes";
		for (int i = 0; i < 300; i++) begin
			clk_ena = rand_bit();
			osc_ena = |rand_bits(2);	// Mostly on
			cycle();
		end

		test_name = "reset_release";
		clk_ena = 1'b1;
		osc_ena = 1'b1;
		wait_sync(1'b0, "sync_reset release");
		osc_ena = 1'b0;
		cycle();
		osc_ena = 1'b1;
		wait_sync(1'b1, "sync_reset to rise after oscillator drop");
		wait_sync(1'b0, "second sync_reset release");

		test_name = "div";
		repeat (1100) cycle();
		apb_read(dmg_clk_pkg::ADDR_DIV);
		apb_write(dmg_clk_pkg::ADDR_DIV, rand_bits(8));
		apb_read(dmg_clk_pkg::ADDR_DIV);

		test_name = "timer";
		for (int i = 0; i < 6; i++) begin
			int n;
			logic [7:0] sel_code;
			sel_code = rand_bits(2);
			apb_write(dmg_clk_pkg::ADDR_TAC, {5'b0, 1'b1, sel_code[1:0]});
			apb_write(dmg_clk_pkg::ADDR_TMA, rand_bits(8));
			apb_write(dmg_clk_pkg::ADDR_TIMA, 8'hFC | rand_bits(2));
			apb_read(dmg_clk_pkg::ADDR_TAC);
			apb_read(dmg_clk_pkg::ADDR_TMA);
			n = 0;
			while (timer_irq !== 1'b1) begin
				cycle();
				n++;
				if (n > 6000) begin
					$display("Timeout waiting for timer_irq after TIMA overflow");
					fail_now();
				end
			end
			apb_read(dmg_clk_pkg::ADDR_TIMA);
			apb_read(dmg_clk_pkg::ADDR_STATUS);
			apb_write(dmg_clk_pkg::ADDR_STATUS, 8'h01);
			apb_read(dmg_clk_pkg::ADDR_STATUS);
		end

		test_name = "apb_errors";
		for (int i = 0; i < 10; i++) begin
			logic [2:0] bad;
			logic [7:0] pick;
			pick = rand_bits(2) % 8'd3;
			bad = 3'd5 + pick[2:0];
			apb_write(bad, rand_bits(8));
			apb_read(bad);
			for (int a = 0; a <= 4; a++)
				apb_read(a[2:0]);
		end

		assert_fails = u_dmg_clk_top.u_clk_phase_gen.u_phase_checks.fail_count
			+ u_dmg_clk_top.u_reset_seq.u_reset_checks.fail_count;
		if (assert_fails == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times", assert_fails);
			fail_now();
		end
	end

endmodule

// File: build.f
hdl/dmg_clk_pkg.sv
hdl/clk_phase_gen.sv
hdl/reset_seq.sv
hdl/div_timer.sv
hdl/timer_apb_regs.sv
hdl/dmg_clk_top.sv
sim/dmg_clk_assertions.sv
sim/tb_dmg_clk.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall \
	-f build.f \
	--top-module tb_dmg_clk \
	-Mdir obj_dir

./obj_dir/Vtb_dmg_clk > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
